// ==== tb.f ====
+incdir+verilog
verilog/tq_pkg.sv
verilog/tq_match.sv
verilog/tq_entries.sv
verilog/tq_issue.sv
verilog/cache_tq.sv
bench/tb_cache_tq.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_cache_tq -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// ==== bench/tb_cache_tq.sv ====
// directed tests only; pipe and far memory are played by tasks and every strobe lasts one cycle
`timescale 1ns/10ps
`include "tq_macros.svh"

module tb_cache_tq;

localparam int MAX_WAIT = 12;                  // cycles before a wait gives up

logic                    clk;
logic                    rst_n;
logic                    core_req_valid, core_req_wr, stall, rsp_valid;
logic [`TQ_ADDR_W-1:0]   core_req_address, rsp_address, lu_req_address, lu_rsp_address;
logic [`TQ_WORD_W-1:0]   core_req_data, rsp_data, lu_req_data;
logic [`TQ_REG_ID_W-1:0] core_req_reg_id, rsp_reg_id, lu_req_reg_id, lu_rsp_reg_id;
logic                    fm_rsp_valid, lu_req_valid, lu_req_mb_hit_cancel;
logic                    lu_req_rd_indication, lu_req_wr_indication;
logic                    lu_rsp_valid, lu_rsp_rd_indication;
logic [`TQ_ID_W-1:0]     fm_rsp_tq_id, lu_req_tq_id, lu_rsp_tq_id;
logic [1:0]              lu_req_op, lu_rsp_op, lu_rsp_result;
tq_pkg::t_cl             fm_rsp_data, lu_req_cl_data, lu_rsp_cl_data;

int          errors;
int          timeouts;
logic [31:0] lfsr;                             // random data source

cache_tq cache_tq_i (.*);

always #4 clk = ~clk;                          // 8 ns period

//========================================
// random data
//========================================
// Galois form of x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

task automatic rand_word(output logic [`TQ_WORD_W-1:0] w);
    for (int b = 0; b < `TQ_WORD_W; b++) begin
        lfsr = lfsr_step(lfsr);
        w[b] = lfsr[0];                        // one step per bit
    end
endtask

task automatic rand_line(output tq_pkg::t_cl l);
    logic [`TQ_WORD_W-1:0] w;
    for (int i = 0; i < `TQ_WORDS_IN_CL; i++) begin
        rand_word(w);
        l.word[i] = w;
    end
endtask

//========================================
// compare tasks
//========================================
task automatic check_word(input string name, input logic [`TQ_WORD_W-1:0] got, want);
    if (got !== want) begin
        errors++;
        $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
    end
endtask

task automatic check_line(input string name, input tq_pkg::t_cl got, want);
    if (got !== want) begin
        errors++;
        $display("Error at %0t: %s is %h, expected %h", $time, name, got.line, want.line);
    end
endtask

task automatic check_code(input string name, input logic [1:0] got, want);
    if (got !== want) begin
        errors++;
        $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, want);
    end
endtask

task automatic check_flag(input string name, input logic got, want);
    if (got !== want) begin
        errors++;
        $display("Error at %0t: %s is %b, expected %b", $time, name, got, want);
    end
endtask

task automatic check_lookup(input logic [1:0] op, input logic [`TQ_ID_W-1:0] id,
                            input logic [`TQ_ADDR_W-1:0] addr, input logic cancel, rd, wr);
    check_flag("lu_req_valid", lu_req_valid, 1'b1);
    check_code("lu_req_op", lu_req_op, op);
    check_code("lu_req_tq_id", lu_req_tq_id, id);
    check_word("lu_req_address", `TQ_WORD_W'(lu_req_address), `TQ_WORD_W'(addr));
    check_flag("lu_req_mb_hit_cancel", lu_req_mb_hit_cancel, cancel);
    check_flag("lu_req_rd_indication", lu_req_rd_indication, rd);
    check_flag("lu_req_wr_indication", lu_req_wr_indication, wr);
endtask

task automatic check_rsp(input logic [`TQ_WORD_W-1:0] data, input logic [`TQ_ADDR_W-1:0] addr,
                         input logic [`TQ_REG_ID_W-1:0] reg_id);
    check_flag("rsp_valid", rsp_valid, 1'b1);
    check_word("rsp_data", rsp_data, data);
    check_word("rsp_address", `TQ_WORD_W'(rsp_address), `TQ_WORD_W'(addr));
    check_word("rsp_reg_id", `TQ_WORD_W'(rsp_reg_id), `TQ_WORD_W'(reg_id));
endtask

//========================================
// core, pipe and far memory drivers
//========================================
// each driver owns one cycle and returns at the falling edge with outputs settled
task automatic send_req(input logic wr, input logic [`TQ_ADDR_W-1:0] addr,
                        input logic [`TQ_WORD_W-1:0] data, input logic [`TQ_REG_ID_W-1:0] reg_id);
    @(posedge clk);
    core_req_valid   <= 1'b1;
    core_req_wr      <= wr;
    core_req_address <= addr;
    core_req_data    <= data;
    core_req_reg_id  <= reg_id;
    lu_rsp_valid     <= 1'b0;
    fm_rsp_valid     <= 1'b0;
    @(negedge clk);
endtask

task automatic send_lu_rsp(input logic [1:0] op, res, input logic [`TQ_ID_W-1:0] id,
                           input logic [`TQ_ADDR_W-1:0] addr, input tq_pkg::t_cl line,
                           input logic [`TQ_REG_ID_W-1:0] reg_id, input logic rd);
    @(posedge clk);
    core_req_valid       <= 1'b0;
    fm_rsp_valid         <= 1'b0;
    lu_rsp_valid         <= 1'b1;
    lu_rsp_op            <= op;
    lu_rsp_result        <= res;
    lu_rsp_tq_id         <= id;
    lu_rsp_address       <= addr;
    lu_rsp_cl_data       <= line;
    lu_rsp_reg_id        <= reg_id;
    lu_rsp_rd_indication <= rd;
    @(negedge clk);
endtask

task automatic send_fill(input logic [`TQ_ID_W-1:0] id, input tq_pkg::t_cl line);
    @(posedge clk);
    core_req_valid <= 1'b0;
    lu_rsp_valid   <= 1'b0;
    fm_rsp_valid   <= 1'b1;                    // far memory has no back-pressure
    fm_rsp_tq_id   <= id;
    fm_rsp_data    <= line;
    @(negedge clk);
endtask

task automatic idle_cycle();
    @(posedge clk);
    core_req_valid <= 1'b0;
    lu_rsp_valid   <= 1'b0;
    fm_rsp_valid   <= 1'b0;
    @(negedge clk);
endtask

// leaves the run at the cycle that shows the FILL lookup
task automatic wait_fill_lookup();
    int n;
    n = 0;
    idle_cycle();
    while (!(lu_req_valid && lu_req_op == `TQ_LU_FILL) && n < MAX_WAIT) begin
        idle_cycle();
        n++;
    end
    if (!(lu_req_valid && lu_req_op == `TQ_LU_FILL)) begin
        timeouts++;
        $display("timeout: no FILL lookup was issued within %0d cycles", MAX_WAIT);
    end
endtask

task automatic wait_stall_low();
    int n;
    n = 0;
    while (stall && n < MAX_WAIT) begin
        idle_cycle();
        n++;
    end
    if (stall) begin
        timeouts++;
        $display("timeout: stall stayed high for %0d cycles", MAX_WAIT);
    end
endtask

//========================================
// directed tests
//========================================
task automatic test_read_hit();
    tq_pkg::t_cl line;
    rand_line(line);
    send_req(1'b0, 20'h1a348, '0, 5'd5);       // word 2
    check_lookup(`TQ_LU_RD, 2'd0, 20'h1a348, 1'b0, 1'b1, 1'b0);
    check_flag("stall", stall, 1'b0);
    send_lu_rsp(`TQ_LU_RD, `TQ_RES_HIT, 2'd0, 20'h1a348, line, 5'd5, 1'b1);
    check_rsp(line.word[2], 20'h1a348, 5'd5);
endtask

task automatic test_read_miss_fill();
    tq_pkg::t_cl fill;
    rand_line(fill);
    send_req(1'b0, 20'h2b706, '0, 5'd7);       // word 1, byte 2
    check_lookup(`TQ_LU_RD, 2'd0, 20'h2b706, 1'b0, 1'b1, 1'b0);
    send_lu_rsp(`TQ_LU_RD, `TQ_RES_MISS, 2'd0, 20'h2b706, '0, 5'd7, 1'b1);
    check_flag("rsp_valid", rsp_valid, 1'b0);  // a miss answers nothing
    send_fill(2'd0, fill);
    wait_fill_lookup();
    check_lookup(`TQ_LU_FILL, 2'd0, 20'h2b704, 1'b0, 1'b1, 1'b0);   // byte bits cleared
    check_line("lu_req_cl_data", lu_req_cl_data, fill);
    check_word("lu_req_reg_id", `TQ_WORD_W'(lu_req_reg_id), `TQ_WORD_W'(5'd7));
    send_lu_rsp(`TQ_LU_FILL, `TQ_RES_FILL, 2'd0, 20'h2b704, fill, 5'd7, 1'b1);
    check_rsp(fill.word[1], 20'h2b704, 5'd7);
endtask

task automatic test_write_merge();
    tq_pkg::t_cl fill;
    tq_pkg::t_cl want;
    logic [`TQ_WORD_W-1:0] d1;
    logic [`TQ_WORD_W-1:0] d3;
    rand_word(d1);
    rand_word(d3);
    rand_line(fill);
    send_req(1'b1, 20'h3c504, d1, 5'd0);
    check_lookup(`TQ_LU_WR, 2'd0, 20'h3c504, 1'b0, 1'b0, 1'b1);
    check_word("lu_req_data", lu_req_data, d1);
    send_lu_rsp(`TQ_LU_WR, `TQ_RES_MISS, 2'd0, 20'h3c504, '0, 5'd0, 1'b0);
    send_req(1'b1, 20'h3c50c, d3, 5'd0);       // same line, word 3
    check_lookup(`TQ_LU_WR, 2'd0, 20'h3c50c, 1'b1, 1'b0, 1'b1);
    send_fill(2'd0, fill);
    wait_fill_lookup();
    want         = fill;                       // written words survive the fill
    want.word[1] = d1;
    want.word[3] = d3;
    check_lookup(`TQ_LU_FILL, 2'd0, 20'h3c504, 1'b0, 1'b0, 1'b1);
    check_line("lu_req_cl_data", lu_req_cl_data, want);
endtask

task automatic test_read_after_write();
    tq_pkg::t_cl fill;
    tq_pkg::t_cl want;
    logic [`TQ_WORD_W-1:0] d0;
    rand_word(d0);
    rand_line(fill);
    send_req(1'b1, 20'h4d600, d0, 5'd1);
    check_lookup(`TQ_LU_WR, 2'd0, 20'h4d600, 1'b0, 1'b0, 1'b1);
    send_lu_rsp(`TQ_LU_WR, `TQ_RES_MISS, 2'd0, 20'h4d600, '0, 5'd1, 1'b0);
    send_req(1'b0, 20'h4d608, '0, 5'd9);       // read merges and takes offset and reg id
    check_lookup(`TQ_LU_RD, 2'd0, 20'h4d608, 1'b1, 1'b1, 1'b0);
    send_fill(2'd0, fill);
    wait_fill_lookup();
    want         = fill;
    want.word[0] = d0;
    check_lookup(`TQ_LU_FILL, 2'd0, 20'h4d608, 1'b0, 1'b1, 1'b1);
    check_line("lu_req_cl_data", lu_req_cl_data, want);
    check_word("lu_req_reg_id", `TQ_WORD_W'(lu_req_reg_id), `TQ_WORD_W'(5'd9));
    send_lu_rsp(`TQ_LU_FILL, `TQ_RES_FILL, 2'd0, 20'h4d608, want, 5'd9, 1'b1);
    check_rsp(want.word[2], 20'h4d608, 5'd9);
endtask

task automatic test_queue_full();
    tq_pkg::t_cl fill;
    logic [`TQ_ADDR_W-1:0] a;
    rand_line(fill);
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        a = 20'h5e000 + `TQ_ADDR_W'(i * 16);   // one line each
        send_req(1'b0, a, '0, `TQ_REG_ID_W'(i));
        check_code("lu_req_tq_id", lu_req_tq_id, `TQ_ID_W'(i));
        send_lu_rsp(`TQ_LU_RD, `TQ_RES_MISS, `TQ_ID_W'(i), a, '0, `TQ_REG_ID_W'(i), 1'b1);
    end
    check_flag("stall", stall, 1'b1);
    send_fill(2'd2, fill);
    send_req(1'b0, 20'h6f000, '0, 5'd20);      // held request keeps the ready fill waiting
    check_flag("lu_req_valid", lu_req_valid, 1'b0);
    wait_fill_lookup();
    check_code("lu_req_tq_id", lu_req_tq_id, 2'd2);
    wait_stall_low();
    send_req(1'b0, 20'h6f000, '0, 5'd20);
    check_lookup(`TQ_LU_RD, 2'd2, 20'h6f000, 1'b0, 1'b1, 1'b0);    // freed index reused
endtask

initial begin
    errors               = 0;
    timeouts             = 0;
    lfsr                 = 32'hcd9ae6c2;
    clk                  = 1'b0;
    rst_n                = 1'b0;
    core_req_valid       = 1'b0;
    core_req_wr          = 1'b0;
    core_req_address     = '0;
    core_req_data        = '0;
    core_req_reg_id      = '0;
    fm_rsp_valid         = 1'b0;
    fm_rsp_tq_id         = '0;
    fm_rsp_data          = '0;
    lu_rsp_valid         = 1'b0;
    lu_rsp_op            = `TQ_LU_NONE;
    lu_rsp_result        = `TQ_RES_HIT;
    lu_rsp_tq_id         = '0;
    lu_rsp_address       = '0;
    lu_rsp_cl_data       = '0;
    lu_rsp_reg_id        = '0;
    lu_rsp_rd_indication = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("stall", stall, 1'b0);          // all entries idle
    check_flag("lu_req_valid", lu_req_valid, 1'b0);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    test_read_hit();
    test_read_miss_fill();
    test_write_merge();
    test_read_after_write();
    test_queue_full();
    idle_cycle();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

// ==== verilog/cache_tq.sv ====
// queue top; core and far memory use plain valid strobes, stall is the only back-pressure
`timescale 1ns/10ps
`include "tq_macros.svh"

module cache_tq (
    input  logic                      clk,
    input  logic                      rst_n,
    // core
    input  logic                      core_req_valid,
    input  logic                      core_req_wr,
    input  logic [`TQ_ADDR_W-1:0]     core_req_address,
    input  logic [`TQ_WORD_W-1:0]     core_req_data,
    input  logic [`TQ_REG_ID_W-1:0]   core_req_reg_id,
    output logic                      stall,
    output logic                      rsp_valid,
    output logic [`TQ_WORD_W-1:0]     rsp_data,
    output logic [`TQ_ADDR_W-1:0]     rsp_address,
    output logic [`TQ_REG_ID_W-1:0]   rsp_reg_id,
    // far memory
    input  logic                      fm_rsp_valid,
    input  logic [`TQ_ID_W-1:0]       fm_rsp_tq_id,
    input  tq_pkg::t_cl               fm_rsp_data,
    // lookup pipe
    output logic                      lu_req_valid,
    output logic [1:0]                lu_req_op,
    output logic [`TQ_ADDR_W-1:0]     lu_req_address,
    output logic [`TQ_WORD_W-1:0]     lu_req_data,
    output tq_pkg::t_cl               lu_req_cl_data,
    output logic [`TQ_ID_W-1:0]       lu_req_tq_id,
    output logic                      lu_req_mb_hit_cancel,
    output logic                      lu_req_rd_indication,
    output logic                      lu_req_wr_indication,
    output logic [`TQ_REG_ID_W-1:0]   lu_req_reg_id,
    input  logic                      lu_rsp_valid,
    input  logic [1:0]                lu_rsp_op,
    input  logic [1:0]                lu_rsp_result,
    input  logic [`TQ_ID_W-1:0]       lu_rsp_tq_id,
    input  logic [`TQ_ADDR_W-1:0]     lu_rsp_address,
    input  tq_pkg::t_cl               lu_rsp_cl_data,
    input  logic [`TQ_REG_ID_W-1:0]   lu_rsp_reg_id,
    input  logic                      lu_rsp_rd_indication
);

// match -> entries, issue
logic                     req_accept;
logic [`TQ_NUM_ENTRY-1:0] alloc_onehot;
logic [`TQ_NUM_ENTRY-1:0] rd_hit_onehot;
logic [`TQ_NUM_ENTRY-1:0] wr_hit_onehot;
logic [`TQ_ID_W-1:0]      lu_tq_id;
logic                     mb_hit_cancel;

// entries -> match, issue
logic [`TQ_NUM_ENTRY-1:0]                                state_free;
logic [`TQ_NUM_ENTRY-1:0]                                state_active;
logic [`TQ_NUM_ENTRY-1:0]                                fill_ready;
logic [`TQ_NUM_ENTRY-1:0][`TQ_MSB_TAG:`TQ_LSB_SET]       entry_cl_addr;
logic [`TQ_NUM_ENTRY-1:0][`TQ_MSB_WORD_OFF:`TQ_LSB_WORD_OFF] entry_word_off;
logic [`TQ_NUM_ENTRY-1:0]                                entry_rd_ind;
logic [`TQ_NUM_ENTRY-1:0]                                entry_wr_ind;
logic [`TQ_NUM_ENTRY-1:0][`TQ_REG_ID_W-1:0]              entry_reg_id;
tq_pkg::t_cl [`TQ_NUM_ENTRY-1:0]                         entry_mb_data;

// issue -> entries
logic [`TQ_NUM_ENTRY-1:0] fill_grant_onehot;

// all ports connect by matching names
tq_match   tq_match_i   (.*);
tq_entries tq_entries_i (.*);
tq_issue   tq_issue_i   (.*);

endmodule

// ==== verilog/tq_issue.sv ====
// combinational lookup mux and response select; a fill goes out only in a cycle with no core request
`timescale 1ns/10ps
`include "tq_macros.svh"

module tq_issue (
    input  logic                                                    core_req_valid,
    input  logic                                                    core_req_wr,
    input  logic [`TQ_ADDR_W-1:0]                                   core_req_address,
    input  logic [`TQ_WORD_W-1:0]                                   core_req_data,
    input  logic [`TQ_REG_ID_W-1:0]                                 core_req_reg_id,
    input  logic                                                    req_accept,
    input  logic [`TQ_ID_W-1:0]                                     lu_tq_id,
    input  logic                                                    mb_hit_cancel,
    input  logic [`TQ_NUM_ENTRY-1:0]                                fill_ready,
    input  logic [`TQ_NUM_ENTRY-1:0][`TQ_MSB_TAG:`TQ_LSB_SET]       entry_cl_addr,
    input  logic [`TQ_NUM_ENTRY-1:0][`TQ_MSB_WORD_OFF:`TQ_LSB_WORD_OFF] entry_word_off,
    input  logic [`TQ_NUM_ENTRY-1:0]                                entry_rd_ind,
    input  logic [`TQ_NUM_ENTRY-1:0]                                entry_wr_ind,
    input  logic [`TQ_NUM_ENTRY-1:0][`TQ_REG_ID_W-1:0]              entry_reg_id,
    input  tq_pkg::t_cl [`TQ_NUM_ENTRY-1:0]                         entry_mb_data,
    input  logic                                                    lu_rsp_valid,
    input  logic [1:0]                                              lu_rsp_op,
    input  logic [1:0]                                              lu_rsp_result,
    input  logic [`TQ_ADDR_W-1:0]                                   lu_rsp_address,
    input  tq_pkg::t_cl                                             lu_rsp_cl_data,
    input  logic [`TQ_REG_ID_W-1:0]                                 lu_rsp_reg_id,
    input  logic                                                    lu_rsp_rd_indication,
    output logic                                                    lu_req_valid,
    output logic [1:0]                                              lu_req_op,
    output logic [`TQ_ADDR_W-1:0]                                   lu_req_address,
    output logic [`TQ_WORD_W-1:0]                                   lu_req_data,
    output tq_pkg::t_cl                                             lu_req_cl_data,
    output logic [`TQ_ID_W-1:0]                                     lu_req_tq_id,
    output logic                                                    lu_req_mb_hit_cancel,
    output logic                                                    lu_req_rd_indication,
    output logic                                                    lu_req_wr_indication,
    output logic [`TQ_REG_ID_W-1:0]                                 lu_req_reg_id,
    output logic [`TQ_NUM_ENTRY-1:0]                                fill_grant_onehot,
    output logic                                                    rsp_valid,
    output logic [`TQ_WORD_W-1:0]                                   rsp_data,
    output logic [`TQ_ADDR_W-1:0]                                   rsp_address,
    output logic [`TQ_REG_ID_W-1:0]                                 rsp_reg_id
);

logic [`TQ_NUM_ENTRY-1:0] first_fill;
logic [`TQ_ID_W-1:0]      fill_id;
logic                     slot_free;   // no core request this cycle

// fixed priority to the lowest fill-ready index
always_comb begin
    first_fill = '0;
    fill_id    = '0;
    for (int i = `TQ_NUM_ENTRY-1; i >= 0; i--) begin
        if (fill_ready[i]) begin
            first_fill    = '0;
            first_fill[i] = 1'b1;
            fill_id       = `TQ_ID_W'(i);
        end
    end
end

// a stalled core request still holds the slot
assign slot_free         = !core_req_valid;
assign fill_grant_onehot = slot_free ? first_fill : '0;

//========================================
// lookup request mux
//========================================
always_comb begin
    lu_req_valid         = 1'b0;
    lu_req_op            = `TQ_LU_NONE;
    lu_req_address       = '0;
    lu_req_data          = '0;
    lu_req_cl_data       = '0;
    lu_req_tq_id         = '0;
    lu_req_mb_hit_cancel = 1'b0;
    lu_req_rd_indication = 1'b0;
    lu_req_wr_indication = 1'b0;
    lu_req_reg_id        = '0;
    if (req_accept) begin
        lu_req_valid         = 1'b1;
        lu_req_op            = core_req_wr ? `TQ_LU_WR : `TQ_LU_RD;
        lu_req_address       = core_req_address;
        lu_req_data          = core_req_data;
        lu_req_tq_id         = lu_tq_id;
        lu_req_mb_hit_cancel = mb_hit_cancel;
        lu_req_rd_indication = !core_req_wr;
        lu_req_wr_indication = core_req_wr;
        lu_req_reg_id        = core_req_reg_id;
    end else if (|fill_grant_onehot) begin
        lu_req_valid         = 1'b1;
        lu_req_op            = `TQ_LU_FILL;
        lu_req_address       = {entry_cl_addr[fill_id], entry_word_off[fill_id],
                                {`TQ_LSB_WORD_OFF{1'b0}}};         // word aligned
        lu_req_cl_data       = entry_mb_data[fill_id];             // merged line
        lu_req_tq_id         = fill_id;
        lu_req_rd_indication = entry_rd_ind[fill_id];
        lu_req_wr_indication = entry_wr_ind[fill_id];
        lu_req_reg_id        = entry_reg_id[fill_id];
    end
end

//========================================
// core response
//========================================
assign rsp_valid = lu_rsp_valid &&
                   (((lu_rsp_op == `TQ_LU_RD) && (lu_rsp_result == `TQ_RES_HIT)) ||
                    ((lu_rsp_op == `TQ_LU_FILL) && lu_rsp_rd_indication));
assign rsp_data    = lu_rsp_cl_data.word[lu_rsp_address[`TQ_MSB_WORD_OFF:`TQ_LSB_WORD_OFF]];
assign rsp_address = lu_rsp_address;
assign rsp_reg_id  = lu_rsp_reg_id;

endmodule

// ==== verilog/tq_entries.sv ====
// entry registers update one cycle after the event; only state is reset, payload loads on alloc
`timescale 1ns/10ps
`include "tq_macros.svh"

module tq_entries (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    core_req_wr,
    input  logic [`TQ_ADDR_W-1:0]                                   core_req_address,
    input  logic [`TQ_WORD_W-1:0]                                   core_req_data,
    input  logic [`TQ_REG_ID_W-1:0]                                 core_req_reg_id,
    input  logic [`TQ_NUM_ENTRY-1:0]                                alloc_onehot,
    input  logic [`TQ_NUM_ENTRY-1:0]                                rd_hit_onehot,
    input  logic [`TQ_NUM_ENTRY-1:0]                                wr_hit_onehot,
    input  logic                                                    lu_rsp_valid,
    input  logic [1:0]                                              lu_rsp_result,
    input  logic [`TQ_ID_W-1:0]                                     lu_rsp_tq_id,
    input  logic                                                    fm_rsp_valid,
    input  logic [`TQ_ID_W-1:0]                                     fm_rsp_tq_id,
    input  tq_pkg::t_cl                                             fm_rsp_data,
    input  logic [`TQ_NUM_ENTRY-1:0]                                fill_grant_onehot,
    output logic [`TQ_NUM_ENTRY-1:0]                                state_free,
    output logic [`TQ_NUM_ENTRY-1:0]                                state_active,
    output logic [`TQ_NUM_ENTRY-1:0]                                fill_ready,
    output logic [`TQ_NUM_ENTRY-1:0][`TQ_MSB_TAG:`TQ_LSB_SET]       entry_cl_addr,
    output logic [`TQ_NUM_ENTRY-1:0][`TQ_MSB_WORD_OFF:`TQ_LSB_WORD_OFF] entry_word_off,
    output logic [`TQ_NUM_ENTRY-1:0]                                entry_rd_ind,
    output logic [`TQ_NUM_ENTRY-1:0]                                entry_wr_ind,
    output logic [`TQ_NUM_ENTRY-1:0][`TQ_REG_ID_W-1:0]              entry_reg_id,
    output tq_pkg::t_cl [`TQ_NUM_ENTRY-1:0]                         entry_mb_data
);

logic [`TQ_NUM_ENTRY-1:0][1:0]                 state;
logic [`TQ_NUM_ENTRY-1:0][`TQ_WORDS_IN_CL-1:0] mod_q;   // per-word modified mask
logic [`TQ_NUM_ENTRY-1:0][`TQ_WORDS_IN_CL-1:0] mod_d;
tq_pkg::t_cl [`TQ_NUM_ENTRY-1:0]               mb_d;
logic [`TQ_NUM_ENTRY-1:0]                      rsp_me;  // lookup response for this entry
logic [`TQ_NUM_ENTRY-1:0]                      fill_me; // far-memory line for this entry
logic [`TQ_MSB_WORD_OFF:`TQ_LSB_WORD_OFF]      req_off;

assign req_off = core_req_address[`TQ_MSB_WORD_OFF:`TQ_LSB_WORD_OFF];

//========================================
// decode and merge buffer next value
//========================================
always_comb begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        state_free[i]   = (state[i] == `TQ_S_IDLE);
        state_active[i] = !state_free[i];                 // lookup, wait-fill or fill-ready
        fill_ready[i]   = (state[i] == `TQ_S_FILL_READY);
        rsp_me[i]  = lu_rsp_valid && (lu_rsp_tq_id == `TQ_ID_W'(i)) &&
                     (state[i] == `TQ_S_LU_CORE);
        fill_me[i] = fm_rsp_valid && (fm_rsp_tq_id == `TQ_ID_W'(i)) &&
                     (state[i] == `TQ_S_WAIT_FILL);

        // a fresh entry starts from an empty line
        mod_d[i] = alloc_onehot[i] ? '0 : mod_q[i];
        mb_d[i]  = alloc_onehot[i] ? '0 : entry_mb_data[i];
        if ((alloc_onehot[i] && core_req_wr) || wr_hit_onehot[i]) begin
            mb_d[i].word[req_off] = core_req_data;
            mod_d[i][req_off]     = 1'b1;
        end
        // fill after the write so a same-cycle write keeps its word
        if (fill_me[i]) begin
            for (int w = 0; w < `TQ_WORDS_IN_CL; w++) begin
                if (!mod_d[i][w]) mb_d[i].word[w] = fm_rsp_data.word[w];
            end
        end
    end
end

//========================================
// entry FSM
//========================================
always_ff @(posedge clk) begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        if (!rst_n) begin
            state[i] <= `TQ_S_IDLE;
        end else begin
            case (state[i])
                `TQ_S_IDLE: if (alloc_onehot[i]) state[i] <= `TQ_S_LU_CORE;
                `TQ_S_LU_CORE: begin
                    if (rsp_me[i]) begin
                        case (lu_rsp_result)
                            `TQ_RES_HIT:  state[i] <= `TQ_S_IDLE;
                            `TQ_RES_MISS: state[i] <= `TQ_S_WAIT_FILL;
                            `TQ_RES_FILL: state[i] <= `TQ_S_LU_CORE; // stale fill of an older owner
                            default:      state[i] <= state[i];
                        endcase
                    end
                end
                `TQ_S_WAIT_FILL:  if (fill_me[i]) state[i] <= `TQ_S_FILL_READY;
                `TQ_S_FILL_READY: if (fill_grant_onehot[i]) state[i] <= `TQ_S_IDLE;
                default:          state[i] <= `TQ_S_IDLE;
            endcase
        end
    end
end

// payload
always_ff @(posedge clk) begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        if (alloc_onehot[i]) begin
            entry_cl_addr[i]  <= core_req_address[`TQ_MSB_TAG:`TQ_LSB_SET];
            entry_word_off[i] <= req_off;
            entry_reg_id[i]   <= core_req_reg_id;
            entry_rd_ind[i]   <= !core_req_wr;
            entry_wr_ind[i]   <= core_req_wr;
        end
        if (rd_hit_onehot[i]) begin                 // read after write, response goes to the read
            entry_rd_ind[i]   <= 1'b1;
            entry_word_off[i] <= req_off;
            entry_reg_id[i]   <= core_req_reg_id;
        end
        if (wr_hit_onehot[i]) entry_wr_ind[i] <= 1'b1;
        entry_mb_data[i] <= mb_d[i];
        mod_q[i]         <= mod_d[i];
    end
end

endmodule

// ==== verilog/tq_match.sv ====
// request side is combinational; lowest index wins among hits and among free entries
`timescale 1ns/10ps
`include "tq_macros.svh"

module tq_match (
    input  logic                                              core_req_valid,
    input  logic                                              core_req_wr,
    input  logic [`TQ_ADDR_W-1:0]                             core_req_address,
    input  logic [`TQ_NUM_ENTRY-1:0]                          state_free,
    input  logic [`TQ_NUM_ENTRY-1:0]                          state_active,
    input  logic [`TQ_NUM_ENTRY-1:0][`TQ_MSB_TAG:`TQ_LSB_SET] entry_cl_addr,
    input  logic [`TQ_NUM_ENTRY-1:0]                          entry_rd_ind,
    output logic                                              stall,
    output logic                                              req_accept,
    output logic [`TQ_NUM_ENTRY-1:0]                          alloc_onehot,
    output logic [`TQ_NUM_ENTRY-1:0]                          rd_hit_onehot,
    output logic [`TQ_NUM_ENTRY-1:0]                          wr_hit_onehot,
    output logic [`TQ_ID_W-1:0]                               lu_tq_id,
    output logic                                              mb_hit_cancel
);

logic [`TQ_NUM_ENTRY-1:0] line_hit;    // same line, still mergeable
logic [`TQ_NUM_ENTRY-1:0] first_hit;
logic [`TQ_NUM_ENTRY-1:0] first_free;
logic [`TQ_ID_W-1:0]      hit_id;
logic [`TQ_ID_W-1:0]      free_id;
logic                     any_hit;

// walk down so the last write is the lowest index
always_comb begin
    first_hit  = '0;
    first_free = '0;
    hit_id     = '0;
    free_id    = '0;
    for (int i = `TQ_NUM_ENTRY-1; i >= 0; i--) begin
        // an entry that already carries a read is closed for merging
        line_hit[i] = state_active[i] && !entry_rd_ind[i] &&
                      (entry_cl_addr[i] == core_req_address[`TQ_MSB_TAG:`TQ_LSB_SET]);
        if (line_hit[i]) begin
            first_hit    = '0;
            first_hit[i] = 1'b1;
            hit_id       = `TQ_ID_W'(i);
        end
        if (state_free[i]) begin
            first_free    = '0;
            first_free[i] = 1'b1;
            free_id       = `TQ_ID_W'(i);
        end
    end
end

assign any_hit    = |line_hit;
assign stall      = ~|state_free;                  // queue full
assign req_accept = core_req_valid && !stall;

//========================================
// merge or allocate
//========================================
assign rd_hit_onehot = (req_accept && !core_req_wr) ? first_hit : '0;
assign wr_hit_onehot = (req_accept &&  core_req_wr) ? first_hit : '0;
assign alloc_onehot  = (req_accept && !any_hit)     ? first_free : '0;

assign mb_hit_cancel = req_accept && any_hit;        // pipe drops the merged lookup
assign lu_tq_id      = any_hit ? hit_id : free_id;   // hit entry, else the new one

endmodule

// ==== verilog/tq_pkg.sv ====
// cache line type; word 0 sits in the low 32 bits of the flat line
`include "tq_macros.svh"

package tq_pkg;

    // same 128 bits seen flat or per word
    typedef union packed {
        logic [`TQ_CL_W-1:0]                        line;
        logic [`TQ_WORDS_IN_CL-1:0][`TQ_WORD_W-1:0] word;
    } t_cl;

endpackage

// ==== verilog/tq_macros.svh ====
// shared widths and codes; line address is always 16 bits and the entry count must match TQ_ID_W
`ifndef TQ_MACROS_SVH
`define TQ_MACROS_SVH

//========================================
// sizes
//========================================
`define TQ_NUM_ENTRY    4
`define TQ_ID_W         2          // log2 of entry count
`define TQ_ADDR_W       20         // byte address
`define TQ_WORD_W       32
`define TQ_WORDS_IN_CL  4
`define TQ_CL_W         128        // words * word width
`define TQ_REG_ID_W     5          // core destination register

//========================================
// address fields
//========================================
`define TQ_LSB_WORD_OFF 2
`define TQ_MSB_WORD_OFF 3
`define TQ_LSB_SET      4          // line address starts here
`define TQ_MSB_TAG      19

//========================================
// codes
//========================================
// lookup opcodes toward the pipe
`define TQ_LU_NONE      2'd0
`define TQ_LU_RD        2'd1
`define TQ_LU_WR        2'd2
`define TQ_LU_FILL      2'd3

// lookup results from the pipe
`define TQ_RES_HIT      2'd0
`define TQ_RES_MISS     2'd1
`define TQ_RES_FILL     2'd2

// entry states
`define TQ_S_IDLE       2'd0
`define TQ_S_LU_CORE    2'd1       // core lookup in flight
`define TQ_S_WAIT_FILL  2'd2       // missed, far memory pending
`define TQ_S_FILL_READY 2'd3       // merged line waits for a free pipe slot

`endif
